/* exec_unit.f */
verilog/exec_pkg.sv
verilog/exec_alu.sv
verilog/exec_branch.sv
verilog/exec_csr.sv
verilog/exec_ctrl.sv
verilog/exec_top.sv
tb/exec_tb.sv

/* tb/exec_tb.sv */
module exec_tb;

  localparam int XLEN       = 32;
  localparam int MAX_TESTS  = 64;
  localparam int RST_CYCLES = 8;
  localparam int RES_W      = 2 * XLEN + 8;

  logic                clk;
  logic                rst;
  logic                in_valid_i;
  exec_pkg::op_class_t op_class_i;
  exec_pkg::alu_op_t   alu_op_i;
  exec_pkg::csr_op_t   csr_op_i;
  logic [11:0]         csr_addr_i;
  logic [4:0]          rd_i;
  logic [XLEN-1:0]     src1_i;
  logic [XLEN-1:0]     src2_i;
  logic [XLEN-1:0]     imm_i;
  logic [XLEN-1:0]     pc_i;
  logic                in_ready_o;
  logic                out_valid_o;
  logic [4:0]          rd_o;
  logic [XLEN-1:0]     wdata_o;
  logic                wen_o;
  logic                redirect_o;
  logic [XLEN-1:0]     npc_o;
  logic                ebreak_o;
  logic                out_ready_i;
  logic                mem_req_o;
  logic                mem_we_o;
  logic [XLEN-1:0]     mem_addr_o;
  logic [XLEN-1:0]     mem_wdata_o;
  logic [XLEN-1:0]     mem_rdata_i;
  logic                mem_rvalid_i;
  logic                mem_wready_i;

  // instruction fields and memory read data per test
  logic [3:0]      t_cls    [MAX_TESTS];
  logic [3:0]      t_aop    [MAX_TESTS];
  logic [1:0]      t_cop    [MAX_TESTS];
  logic [11:0]     t_caddr  [MAX_TESTS];
  logic [4:0]      t_rd     [MAX_TESTS];
  logic [XLEN-1:0] t_src1   [MAX_TESTS];
  logic [XLEN-1:0] t_src2   [MAX_TESTS];
  logic [XLEN-1:0] t_imm    [MAX_TESTS];
  logic [XLEN-1:0] t_pc     [MAX_TESTS];
  logic [XLEN-1:0] t_rdata  [MAX_TESTS];
  // expected outputs per test
  logic            x_wen    [MAX_TESTS];
  logic [XLEN-1:0] x_wdata  [MAX_TESTS];
  logic            x_redir  [MAX_TESTS];
  logic [XLEN-1:0] x_npc    [MAX_TESTS];
  logic            x_ebreak [MAX_TESTS];
  logic [XLEN-1:0] x_maddr  [MAX_TESTS];
  logic [XLEN-1:0] x_mwdata [MAX_TESTS];

  int              num_tests;
  int              accepted;
  int              results;
  int              cycles;
  int              stall;
  bit              loaded;
  integer          seed;
  bit              held;
  logic [RES_W-1:0] held_bits;

  // last request seen by the memory model
  int              mem_idx;
  logic            mem_we_seen;
  logic [XLEN-1:0] mem_addr_seen;
  logic [XLEN-1:0] mem_wdata_seen;

  exec_top #(.XLEN(XLEN)) u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    abort_run();
  endtask

  task automatic report_mismatch(input string msg);
    $display("FAILED at time %0t: %s", $time, msg);
    abort_run();
  endtask

  task automatic check_field(input int idx, input string what, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    assert (got == exp)
      else report_mismatch($sformatf("test %0d %s is %h, expected %h", idx, what, got, exp));
  endtask

  function automatic logic [RES_W-1:0] result_bits();
    return {rd_o, wdata_o, wen_o, redirect_o, npc_o, ebreak_o};
  endfunction

  task automatic load_tests();
    int    fd;
    int    n;
    string line;
    fd = $fopen("tb/exec_tests.txt", "r");
    if (fd == 0) begin
      report_failure("could not open tb/exec_tests.txt");
    end
    num_tests = 0;
    while ($fgets(line, fd)) begin
      // skip comments and blank lines
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      if (num_tests >= MAX_TESTS) begin
        report_failure("too many tests in tb/exec_tests.txt");
      end
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  t_cls[num_tests], t_aop[num_tests], t_cop[num_tests], t_caddr[num_tests],
                  t_rd[num_tests], t_src1[num_tests], t_src2[num_tests], t_imm[num_tests],
                  t_pc[num_tests], t_rdata[num_tests], x_wen[num_tests], x_wdata[num_tests],
                  x_redir[num_tests], x_npc[num_tests], x_ebreak[num_tests],
                  x_maddr[num_tests], x_mwdata[num_tests]);
      if (n != 17) begin
        report_failure($sformatf("malformed line in test file: %s", line));
      end
      num_tests++;
    end
    $fclose(fd);
  endtask

  task automatic drive_test(input int i);
    in_valid_i <= 1'b1;
    op_class_i <= exec_pkg::op_class_t'(t_cls[i]);
    alu_op_i   <= exec_pkg::alu_op_t'(t_aop[i]);
    csr_op_i   <= exec_pkg::csr_op_t'(t_cop[i]);
    csr_addr_i <= t_caddr[i];
    rd_i       <= t_rd[i];
    src1_i     <= t_src1[i];
    src2_i     <= t_src2[i];
    imm_i      <= t_imm[i];
    pc_i       <= t_pc[i];
  endtask

  task automatic check_result();
    int idx;
    bit is_store;
    idx = results;
    assert (idx < accepted)
      else report_failure("a result came out with no instruction pending");
    is_store = (t_cls[idx] == exec_pkg::CLS_STORE);
    check_field(idx, "rd_o", rd_o, t_rd[idx]);
    check_field(idx, "wen_o", wen_o, x_wen[idx]);
    if (x_wen[idx]) begin
      check_field(idx, "wdata_o", wdata_o, x_wdata[idx]);
    end
    check_field(idx, "redirect_o", redirect_o, x_redir[idx]);
    if (x_redir[idx]) begin
      check_field(idx, "npc_o", npc_o, x_npc[idx]);
    end
    check_field(idx, "ebreak_o", ebreak_o, x_ebreak[idx]);
    if (t_cls[idx] == exec_pkg::CLS_LOAD || is_store) begin
      assert (mem_idx == idx)
        else report_failure($sformatf("no memory request was seen for test %0d", idx));
      check_field(idx, "mem_we_o", mem_we_seen, is_store);
      check_field(idx, "mem_addr_o", mem_addr_seen, x_maddr[idx]);
      if (is_store) begin
        check_field(idx, "mem_wdata_o", mem_wdata_seen, x_mwdata[idx]);
      end
    end
    results++;
  endtask

  // answers each request after 0 to 3 cycles
  initial begin : memory_model
    int delay;
    forever begin
      @(posedge clk);
      if (!rst && mem_req_o) begin
        mem_idx        = accepted - 1;
        mem_we_seen    = mem_we_o;
        mem_addr_seen  = mem_addr_o;
        mem_wdata_seen = mem_wdata_o;
        assert (t_cls[mem_idx] == exec_pkg::CLS_LOAD || t_cls[mem_idx] == exec_pkg::CLS_STORE)
          else report_failure("memory request from an instruction that is not a load or store");
        delay = {$random(seed)} % 4;
        repeat (delay) begin
          @(posedge clk);
          assert (mem_req_o && mem_we_o == mem_we_seen && mem_addr_o == mem_addr_seen &&
                  mem_wdata_o == mem_wdata_seen)
            else report_mismatch("memory request changed before its response");
        end
        mem_rvalid_i <= !mem_we_seen;
        mem_wready_i <= mem_we_seen;
        mem_rdata_i  <= t_rdata[mem_idx];
        @(posedge clk);
        mem_rvalid_i <= 1'b0;
        mem_wready_i <= 1'b0;
        @(posedge clk);
        assert (out_valid_o)
          else report_failure("out_valid_o did not rise on the edge after the memory response");
      end
    end
  end

  // results are due one cycle after accept, requests likewise
  initial begin : latency_check
    bit                  pend;
    exec_pkg::op_class_t pend_cls;
    pend = 1'b0;
    forever begin
      @(posedge clk);
      if (pend) begin
        if (pend_cls == exec_pkg::CLS_LOAD || pend_cls == exec_pkg::CLS_STORE) begin
          assert (mem_req_o)
            else report_failure("mem_req_o did not rise on the edge after accept");
        end else begin
          assert (out_valid_o)
            else report_failure("the result was not valid one cycle after accept");
        end
      end
      pend     = !rst && in_valid_i && in_ready_o;
      pend_cls = op_class_i;
    end
  end

  // random back-pressure after each taken result
  initial begin : ready_driver
    stall = 0;
    forever begin
      @(posedge clk);
      if (!rst && out_valid_o && out_ready_i) begin
        stall = {$random(seed)} % 4;
        out_ready_i <= (stall == 0);
      end else if (stall > 0) begin
        stall = stall - 1;
        out_ready_i <= (stall == 0);
      end
    end
  end

  initial begin : result_monitor
    held = 1'b0;
    forever begin
      @(posedge clk);
      if (!rst && out_valid_o) begin
        if (held) begin
          assert (result_bits() == held_bits)
            else report_mismatch("result outputs changed while stalled");
        end
        if (out_ready_i) begin
          check_result();
          held = 1'b0;
        end else begin
          held_bits = result_bits();
          held      = 1'b1;
        end
      end else if (!rst && held) begin
        report_failure("out_valid_o dropped before the result was taken");
      end
    end
  end

  initial begin : watchdog
    wait (loaded);
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > 20 * num_tests + RST_CYCLES) begin
        report_failure($sformatf("timeout after %0d cycles, results did not all arrive", cycles));
      end
    end
  end

  initial begin : stimulus
    seed         = 73;
    rst          = 1'b1;
    in_valid_i   = 1'b0;
    op_class_i   = exec_pkg::CLS_ALU;
    alu_op_i     = exec_pkg::ALU_ADD;
    csr_op_i     = exec_pkg::CSR_RW;
    csr_addr_i   = '0;
    rd_i         = '0;
    src1_i       = '0;
    src2_i       = '0;
    imm_i        = '0;
    pc_i         = '0;
    out_ready_i  = 1'b1;
    mem_rdata_i  = '0;
    mem_rvalid_i = 1'b0;
    mem_wready_i = 1'b0;
    accepted     = 0;
    results      = 0;
    cycles       = 0;
    mem_idx      = -1;
    load_tests();
    if (num_tests == 0) begin
      report_failure("the test file holds no tests");
    end
    loaded = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    assert (!out_valid_o && !mem_req_o && !redirect_o && !ebreak_o && in_ready_o)
      else report_failure("outputs are not in their reset state after reset");
    for (int i = 0; i < num_tests; i++) begin
      drive_test(i);
      @(posedge clk);
      while (!in_ready_o) begin
        @(posedge clk);
      end
      accepted++;
    end
    in_valid_i <= 1'b0;
    while (results < num_tests) begin
      @(posedge clk);
    end
    // room for a stray extra result
    repeat (4) @(posedge clk);
    if (!out_valid_o && !mem_req_o && in_ready_o) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      report_failure("the stage is not idle after the last result");
    end
  end

endmodule

/* tb/exec_tests.txt */
# cls aop cop caddr rd src1 src2 imm pc rdata wen wdata redir npc ebreak maddr mwdata
# all hex; wdata is checked only with wen, npc only with redir, memory only for load/store
0 0 0 0 1 5 3 0 100 0 1 8 0 0 0 0 0
0 1 0 0 2 3 5 0 104 0 1 fffffffe 0 0 0 0 0
0 2 0 0 3 f0f0 ff00 0 108 0 1 f000 0 0 0 0 0
0 3 0 0 4 f0f0 ff00 0 10c 0 1 fff0 0 0 0 0 0
0 4 0 0 5 f0f0 ff00 0 110 0 1 ff0 0 0 0 0 0
0 5 0 0 6 1 24 0 114 0 1 10 0 0 0 0 0
0 6 0 0 7 80000000 4 0 118 0 1 8000000 0 0 0 0 0
0 7 0 0 8 80000000 4 0 11c 0 1 f8000000 0 0 0 0 0
0 8 0 0 9 ffffffff 1 0 120 0 1 1 0 0 0 0 0
0 9 0 0 a ffffffff 1 0 124 0 1 0 0 0 0 0 0
0 0 0 0 0 7 7 0 128 0 0 0 0 0 0 0 0
1 0 0 0 0 5 5 10 200 0 0 0 1 210 0 0 0
1 1 0 0 0 5 5 10 204 0 0 0 0 0 0 0 0
1 2 0 0 0 ffffffff 1 20 208 0 0 0 1 228 0 0 0
1 3 0 0 0 ffffffff 1 20 20c 0 0 0 0 0 0 0 0
1 4 0 0 0 ffffffff 1 20 210 0 0 0 0 0 0 0 0
1 5 0 0 0 ffffffff 1 fffffff0 300 0 0 0 1 2f0 0 0 0
2 0 0 0 1 0 0 40 310 0 1 314 1 350 0 0 0
3 0 0 0 5 1001 0 6 320 0 1 324 1 1006 0 0 0
4 0 0 0 6 1000 0 10 330 cafe0001 1 cafe0001 0 0 0 1010 0
5 0 0 0 0 2000 deadbeef fffffffc 334 0 0 0 0 0 0 1ffc deadbeef
4 0 0 0 c 3000 0 4 338 12345678 1 12345678 0 0 0 3004 0
5 0 0 0 0 40 11223344 8 33c 0 0 0 0 0 0 48 11223344
6 0 1 305 7 800 0 0 400 0 1 0 0 0 0 0 0
6 0 2 305 7 3 0 0 404 0 1 800 0 0 0 0 0
6 0 3 305 7 1 0 0 408 0 1 803 0 0 0 0 0
6 0 2 305 8 0 0 0 40c 0 1 802 0 0 0 0 0
6 0 1 300 9 8 0 0 410 0 1 0 0 0 0 0 0
6 0 2 300 9 0 0 0 414 0 1 8 0 0 0 0 0
7 0 0 0 0 0 0 0 500 0 0 0 1 802 0 0 0
6 0 2 341 a 0 0 0 804 0 1 500 0 0 0 0 0
6 0 2 342 b 0 0 0 808 0 1 b 0 0 0 0 0
6 0 2 300 b 0 0 0 80c 0 1 88 0 0 0 0 0
8 0 0 0 0 0 0 0 810 0 0 0 1 500 0 0 0
6 0 2 300 c 0 0 0 504 0 1 88 0 0 0 0 0
9 0 0 0 0 0 0 0 508 0 0 0 0 0 1 0 0
6 0 1 7c0 d 55 0 0 50c 0 1 0 0 0 0 0 0

/* verilog/exec_alu.sv */
module exec_alu #(
  parameter int XLEN = 32
) (
  input  exec_pkg::alu_op_t  op_i,
  input  logic [XLEN-1:0]    a_i,
  input  logic [XLEN-1:0]    b_i,
  output logic [XLEN-1:0]    res_o
);

  // 5 bit shift amount on rv32, 6 on rv64
  localparam int SHW = (XLEN == 64) ? 6 : 5;

  logic [SHW-1:0] shamt;
  logic           lt_s;
  logic           lt_u;

  assign shamt = b_i[SHW-1:0];
  assign lt_s  = $signed(a_i) < $signed(b_i);
  assign lt_u  = a_i < b_i;

  always_comb begin
    case (op_i)
      exec_pkg::ALU_ADD:  res_o = a_i + b_i;
      exec_pkg::ALU_SUB:  res_o = a_i - b_i;
      exec_pkg::ALU_AND:  res_o = a_i & b_i;
      exec_pkg::ALU_OR:   res_o = a_i | b_i;
      exec_pkg::ALU_XOR:  res_o = a_i ^ b_i;
      exec_pkg::ALU_SLL:  res_o = a_i << shamt;
      exec_pkg::ALU_SRL:  res_o = a_i >> shamt;
      exec_pkg::ALU_SRA:  res_o = $signed(a_i) >>> shamt;
      exec_pkg::ALU_SLT:  res_o = {{(XLEN-1){1'b0}}, lt_s};
      exec_pkg::ALU_SLTU: res_o = {{(XLEN-1){1'b0}}, lt_u};
      default:            res_o = '0;
    endcase
  end

endmodule

/* verilog/exec_branch.sv */
module exec_branch #(
  parameter int XLEN = 32
) (
  input  exec_pkg::op_class_t  op_class_i,
  input  exec_pkg::br_cond_t   cond_i,
  input  logic [XLEN-1:0]      src1_i,
  input  logic [XLEN-1:0]      src2_i,
  input  logic [XLEN-1:0]      pc_i,
  input  logic [XLEN-1:0]      imm_i,
  input  logic [XLEN-1:0]      mtvec_i,
  input  logic [XLEN-1:0]      mepc_i,
  output logic                 redirect_o,
  output logic [XLEN-1:0]      npc_o,
  output logic                 ebreak_o
);

  logic taken;

  always_comb begin
    case (cond_i)
      exec_pkg::BR_EQ:  taken = (src1_i == src2_i);
      exec_pkg::BR_NE:  taken = (src1_i != src2_i);
      exec_pkg::BR_LT:  taken = $signed(src1_i) < $signed(src2_i);
      exec_pkg::BR_GE:  taken = $signed(src1_i) >= $signed(src2_i);
      exec_pkg::BR_LTU: taken = src1_i < src2_i;
      exec_pkg::BR_GEU: taken = src1_i >= src2_i;
      default:          taken = 1'b0;
    endcase
  end

  always_comb begin
    redirect_o = 1'b0;
    npc_o      = pc_i + XLEN'(4);
    case (op_class_i)
      exec_pkg::CLS_BRANCH: begin
        if (taken) begin
          redirect_o = 1'b1;
          npc_o      = pc_i + imm_i;
        end
      end
      exec_pkg::CLS_JAL: begin
        redirect_o = 1'b1;
        npc_o      = pc_i + imm_i;
      end
      exec_pkg::CLS_JALR: begin
        redirect_o = 1'b1;
        npc_o      = (src1_i + imm_i) & ~XLEN'(1);
      end
      exec_pkg::CLS_ECALL: begin
        redirect_o = 1'b1;
        npc_o      = mtvec_i;
      end
      exec_pkg::CLS_MRET: begin
        redirect_o = 1'b1;
        npc_o      = mepc_i;
      end
      default: ;
    endcase
  end

  assign ebreak_o = (op_class_i == exec_pkg::CLS_EBREAK);

endmodule

/* verilog/exec_csr.sv */
module exec_csr #(
  parameter int XLEN = 32
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 commit_i,
  input  exec_pkg::op_class_t  op_class_i,
  input  exec_pkg::csr_op_t    csr_op_i,
  input  logic [11:0]          addr_i,
  input  logic [XLEN-1:0]      src1_i,
  input  logic [XLEN-1:0]      pc_i,
  output logic [XLEN-1:0]      rdata_o,
  output logic [XLEN-1:0]      mtvec_o,
  output logic [XLEN-1:0]      mepc_o
);

  // mstatus bit positions
  localparam int MIE  = 3;
  localparam int MPIE = 7;

  logic [XLEN-1:0] mstatus_q;
  logic [XLEN-1:0] mepc_q;
  logic [XLEN-1:0] mcause_q;
  logic [XLEN-1:0] mtvec_q;
  logic [XLEN-1:0] wval;
  logic            sys_op;

  assign mtvec_o = mtvec_q;
  assign mepc_o  = mepc_q;
  assign sys_op  = (op_class_i == exec_pkg::CLS_CSR) || (op_class_i == exec_pkg::CLS_ECALL) ||
                   (op_class_i == exec_pkg::CLS_MRET);

  always_comb begin
    case (addr_i)
      exec_pkg::CSR_MSTATUS: rdata_o = mstatus_q;
      exec_pkg::CSR_MEPC:    rdata_o = mepc_q;
      exec_pkg::CSR_MCAUSE:  rdata_o = mcause_q;
      exec_pkg::CSR_MTVEC:   rdata_o = mtvec_q;
      default:               rdata_o = '0;
    endcase
  end

  always_comb begin
    case (csr_op_i)
      exec_pkg::CSR_RW: wval = src1_i;
      exec_pkg::CSR_RS: wval = rdata_o | src1_i;
      exec_pkg::CSR_RC: wval = rdata_o & ~src1_i;
      default:          wval = rdata_o;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
      mtvec_q   <= '0;
    end else if (commit_i) begin
      case (op_class_i)
        exec_pkg::CLS_CSR: begin
          case (addr_i)
            exec_pkg::CSR_MSTATUS: mstatus_q <= wval;
            exec_pkg::CSR_MEPC:    mepc_q    <= wval;
            exec_pkg::CSR_MCAUSE:  mcause_q  <= wval;
            exec_pkg::CSR_MTVEC:   mtvec_q   <= wval;
            default: ;
          endcase
        end
        exec_pkg::CLS_ECALL: begin
          mepc_q          <= pc_i;
          mcause_q        <= XLEN'(exec_pkg::CAUSE_ECALL_M);
          mstatus_q[MPIE] <= mstatus_q[MIE];
        end
        exec_pkg::CLS_MRET: begin
          mstatus_q[MIE]  <= mstatus_q[MPIE];
          mstatus_q[MPIE] <= 1'b1;
        end
        default: ;
      endcase
    end
  end

  // a stalled system instruction must not write twice
  a_single_commit: assert property (@(posedge clk) disable iff (rst)
    commit_i && sys_op |=>
      !(commit_i && sys_op && $stable(pc_i) && $stable(addr_i) && $stable(src1_i)));

endmodule

/* verilog/exec_ctrl.sv */
module exec_ctrl #(
  parameter int XLEN = 32
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid_i,
  input  exec_pkg::op_class_t  op_class_i,
  input  exec_pkg::alu_op_t    alu_op_i,
  input  exec_pkg::csr_op_t    csr_op_i,
  input  logic [11:0]          csr_addr_i,
  input  logic [4:0]           rd_i,
  input  logic [XLEN-1:0]      src1_i,
  input  logic [XLEN-1:0]      src2_i,
  input  logic [XLEN-1:0]      imm_i,
  input  logic [XLEN-1:0]      pc_i,
  output logic                 in_ready_o,
  output logic                 out_valid_o,
  output logic [4:0]           rd_o,
  output logic [XLEN-1:0]      wdata_o,
  output logic                 wen_o,
  input  logic                 out_ready_i,
  output logic                 mem_req_o,
  output logic                 mem_we_o,
  output logic [XLEN-1:0]      mem_addr_o,
  output logic [XLEN-1:0]      mem_wdata_o,
  input  logic [XLEN-1:0]      mem_rdata_i,
  input  logic                 mem_rvalid_i,
  input  logic                 mem_wready_i,
  output logic [XLEN-1:0]      src1_o,
  output logic [XLEN-1:0]      src2_o,
  output logic [XLEN-1:0]      imm_o,
  output logic [XLEN-1:0]      pc_o,
  output exec_pkg::alu_op_t    alu_op_o,
  output exec_pkg::op_class_t  op_class_o,
  output exec_pkg::csr_op_t    csr_op_o,
  output logic [11:0]          csr_addr_o,
  input  logic [XLEN-1:0]      alu_res_i,
  input  logic [XLEN-1:0]      csr_rdata_i,
  output logic                 commit_o
);

  typedef enum logic [1:0] {ST_IDLE, ST_MEM_WAIT, ST_HOLD} state_t;

  state_t          state_q;
  logic            accept;
  logic            is_mem;
  logic            mem_done;
  logic [XLEN-1:0] load_data_q;

  assign accept      = in_valid_i && in_ready_o;
  assign is_mem      = (op_class_i == exec_pkg::CLS_LOAD) || (op_class_i == exec_pkg::CLS_STORE);
  assign in_ready_o  = (state_q == ST_IDLE) || ((state_q == ST_HOLD) && out_ready_i);
  assign out_valid_o = (state_q == ST_HOLD);
  assign commit_o    = out_valid_o && out_ready_i;

  // memory port runs straight off the held instruction
  assign mem_req_o   = (state_q == ST_MEM_WAIT);
  assign mem_we_o    = (op_class_o == exec_pkg::CLS_STORE);
  assign mem_addr_o  = src1_o + imm_o;
  assign mem_wdata_o = src2_o;
  assign mem_done    = mem_we_o ? mem_wready_i : mem_rvalid_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= ST_IDLE;
      op_class_o <= exec_pkg::CLS_ALU;
    end else begin
      case (state_q)
        ST_MEM_WAIT: begin
          if (mem_done) begin
            state_q <= ST_HOLD;
          end
        end
        ST_HOLD: begin
          if (out_ready_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: ;
      endcase
      // a new instruction overrides the drain to idle
      if (accept) begin
        state_q    <= is_mem ? ST_MEM_WAIT : ST_HOLD;
        op_class_o <= op_class_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      src1_o     <= src1_i;
      src2_o     <= src2_i;
      imm_o      <= imm_i;
      pc_o       <= pc_i;
      alu_op_o   <= alu_op_i;
      csr_op_o   <= csr_op_i;
      csr_addr_o <= csr_addr_i;
      rd_o       <= rd_i;
    end
    if (mem_req_o && !mem_we_o && mem_rvalid_i) begin
      load_data_q <= mem_rdata_i;
    end
  end

  // result mux
  always_comb begin
    case (op_class_o)
      exec_pkg::CLS_LOAD: wdata_o = load_data_q;
      exec_pkg::CLS_CSR:  wdata_o = csr_rdata_i;
      exec_pkg::CLS_JAL,
      exec_pkg::CLS_JALR: wdata_o = pc_o + XLEN'(4);
      default:            wdata_o = alu_res_i;
    endcase
  end

  always_comb begin
    case (op_class_o)
      exec_pkg::CLS_ALU,
      exec_pkg::CLS_LOAD,
      exec_pkg::CLS_CSR,
      exec_pkg::CLS_JAL,
      exec_pkg::CLS_JALR: wen_o = (rd_o != 5'd0);
      default:            wen_o = 1'b0;
    endcase
  end

  // result is held under back-pressure
  a_out_held: assert property (@(posedge clk) disable iff (rst)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(wdata_o) && $stable(rd_o));

  // request fields hold until the response
  a_req_held: assert property (@(posedge clk) disable iff (rst)
    mem_req_o && !mem_done |=>
      mem_req_o && $stable(mem_we_o) && $stable(mem_addr_o) && $stable(mem_wdata_o));

endmodule

/* verilog/exec_pkg.sv */
package exec_pkg;

  // instruction class from decode
  typedef enum logic [3:0] {
    CLS_ALU    = 4'd0,
    CLS_BRANCH = 4'd1,
    CLS_JAL    = 4'd2,
    CLS_JALR   = 4'd3,
    CLS_LOAD   = 4'd4,
    CLS_STORE  = 4'd5,
    CLS_CSR    = 4'd6,
    CLS_ECALL  = 4'd7,
    CLS_MRET   = 4'd8,
    CLS_EBREAK = 4'd9
  } op_class_t;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_t;

  // carried in alu_op[2:0] for branches
  typedef enum logic [2:0] {
    BR_EQ  = 3'd0,
    BR_NE  = 3'd1,
    BR_LT  = 3'd2,
    BR_GE  = 3'd3,
    BR_LTU = 3'd4,
    BR_GEU = 3'd5
  } br_cond_t;

  // immediate forms come with src1 already zero-extended
  typedef enum logic [1:0] {
    CSR_RW = 2'd1,
    CSR_RS = 2'd2,
    CSR_RC = 2'd3
  } csr_op_t;

  localparam logic [11:0] CSR_MSTATUS = 12'h300;
  localparam logic [11:0] CSR_MTVEC   = 12'h305;
  localparam logic [11:0] CSR_MEPC    = 12'h341;
  localparam logic [11:0] CSR_MCAUSE  = 12'h342;

  localparam int unsigned CAUSE_ECALL_M = 11;

endpackage

/* verilog/exec_top.sv */
module exec_top #(
  parameter int XLEN = 32
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid_i,
  input  exec_pkg::op_class_t  op_class_i,
  input  exec_pkg::alu_op_t    alu_op_i,
  input  exec_pkg::csr_op_t    csr_op_i,
  input  logic [11:0]          csr_addr_i,
  input  logic [4:0]           rd_i,
  input  logic [XLEN-1:0]      src1_i,
  input  logic [XLEN-1:0]      src2_i,
  input  logic [XLEN-1:0]      imm_i,
  input  logic [XLEN-1:0]      pc_i,
  output logic                 in_ready_o,
  output logic                 out_valid_o,
  output logic [4:0]           rd_o,
  output logic [XLEN-1:0]      wdata_o,
  output logic                 wen_o,
  output logic                 redirect_o,
  output logic [XLEN-1:0]      npc_o,
  output logic                 ebreak_o,
  input  logic                 out_ready_i,
  output logic                 mem_req_o,
  output logic                 mem_we_o,
  output logic [XLEN-1:0]      mem_addr_o,
  output logic [XLEN-1:0]      mem_wdata_o,
  input  logic [XLEN-1:0]      mem_rdata_i,
  input  logic                 mem_rvalid_i,
  input  logic                 mem_wready_i
);

  logic [XLEN-1:0]     src1;
  logic [XLEN-1:0]     src2;
  logic [XLEN-1:0]     imm;
  logic [XLEN-1:0]     pc;
  exec_pkg::alu_op_t   alu_op;
  exec_pkg::op_class_t op_class;
  exec_pkg::csr_op_t   csr_op;
  logic [11:0]         csr_addr;
  logic [XLEN-1:0]     alu_res;
  logic [XLEN-1:0]     csr_rdata;
  logic [XLEN-1:0]     mtvec;
  logic [XLEN-1:0]     mepc;
  logic                commit;

  exec_ctrl #(.XLEN(XLEN)) u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid_i),
    .op_class_i  (op_class_i),
    .alu_op_i    (alu_op_i),
    .csr_op_i    (csr_op_i),
    .csr_addr_i  (csr_addr_i),
    .rd_i        (rd_i),
    .src1_i      (src1_i),
    .src2_i      (src2_i),
    .imm_i       (imm_i),
    .pc_i        (pc_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .rd_o        (rd_o),
    .wdata_o     (wdata_o),
    .wen_o       (wen_o),
    .out_ready_i (out_ready_i),
    .mem_req_o   (mem_req_o),
    .mem_we_o    (mem_we_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_rdata_i (mem_rdata_i),
    .mem_rvalid_i(mem_rvalid_i),
    .mem_wready_i(mem_wready_i),
    .src1_o      (src1),
    .src2_o      (src2),
    .imm_o       (imm),
    .pc_o        (pc),
    .alu_op_o    (alu_op),
    .op_class_o  (op_class),
    .csr_op_o    (csr_op),
    .csr_addr_o  (csr_addr),
    .alu_res_i   (alu_res),
    .csr_rdata_i (csr_rdata),
    .commit_o    (commit)
  );

  exec_alu #(.XLEN(XLEN)) u_alu (
    .op_i (alu_op),
    .a_i  (src1),
    .b_i  (src2),
    .res_o(alu_res)
  );

  // branch condition rides in the low alu_op bits
  exec_branch #(.XLEN(XLEN)) u_branch (
    .op_class_i(op_class),
    .cond_i    (exec_pkg::br_cond_t'(alu_op[2:0])),
    .src1_i    (src1),
    .src2_i    (src2),
    .pc_i      (pc),
    .imm_i     (imm),
    .mtvec_i   (mtvec),
    .mepc_i    (mepc),
    .redirect_o(redirect_o),
    .npc_o     (npc_o),
    .ebreak_o  (ebreak_o)
  );

  exec_csr #(.XLEN(XLEN)) u_csr (
    .clk       (clk),
    .rst       (rst),
    .commit_i  (commit),
    .op_class_i(op_class),
    .csr_op_i  (csr_op),
    .addr_i    (csr_addr),
    .src1_i    (src1),
    .pc_i      (pc),
    .rdata_o   (csr_rdata),
    .mtvec_o   (mtvec),
    .mepc_o    (mepc)
  );

endmodule
